/* all.f */
source/uno_pkg.sv
source/hand_store.sv
source/play_selector.sv
source/turn_controller.sv
source/card_player_top.sv
verification/tb_card_player.sv

/* verification/tb_card_player.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_card_player import uno_pkg::*; ();

    localparam int DEAL       = 7;
    localparam int MAX_CYCLES = 400; // six tests of about 40 cycles plus margin

    logic               i_clk;
    logic               i_rst_n;
    logic               i_init;
    logic               i_start;
    logic               i_draw_two;
    logic               i_draw_four;
    logic               i_drawn;
    logic               i_check;
    card_t              i_prev_card;
    card_t              i_drawed_card;
    card_t              o_out_card;
    logic               o_out;
    logic               o_draw_card;
    logic [COUNT_W-1:0] o_hand_num;
    logic [SCORE_W-1:0] o_score;

    int          model_cnt [NUM_COLORS][15]; // wilds sit in colour 0 at values 13 and 14
    int          model_num;
    int          model_score;
    logic [15:0] lfsr        = 16'd16000;
    int          cycle_count = 0;
    int          err_count   = 0;
    int          pass_tests  = 0;
    int          fail_tests  = 0;

    card_player_top #(.INIT_HAND(DEAL)) uut (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
    endfunction

    function automatic card_t make_card(input color_e c, input int v);
        card_t k;
        k.color = c;
        k.value = 4'(v);
        return k;
    endfunction

    // faces score their value, actions 20 and wilds 50
    function automatic int points_of(input card_t k);
        return (k.value >= 4'd13) ? 50 : (k.value >= 4'd10) ? 20 : int'(k.value);
    endfunction

    function automatic int cell_color(input card_t k);
        return (k.value >= WILD_VAL) ? 0 : int'(k.color);
    endfunction

    task automatic model_apply(input card_t k, input int delta);
        model_cnt[cell_color(k)][k.value] += delta;
        model_num   += delta;
        model_score += delta * points_of(k);
    endtask

    function automatic play_choice_t expected_choice(input card_t prev);
        play_choice_t ch;
        color_e       named;
        ch    = '0;
        named = color_e'((int'(prev.color) + 1) % NUM_COLORS);
        for (int c = NUM_COLORS - 1; c >= 0; c--) begin
            for (int v = 0; v < NUM_FACES; v++) begin
                if (model_cnt[c][v] > 0) named = color_e'(c);
            end
        end
        if (prev.value < NUM_FACES) begin
            for (int v = 0; v < NUM_FACES && !ch.valid; v++) begin
                if (model_cnt[prev.color][v] > 0) ch = {1'b1, make_card(prev.color, v)};
            end
            for (int c = 0; c < NUM_COLORS && !ch.valid; c++) begin
                if (model_cnt[c][prev.value] > 0)
                    ch = {1'b1, make_card(color_e'(c), prev.value)};
            end
        end
        if (!ch.valid && model_cnt[0][WILD_VAL] > 0) begin
            ch = {1'b1, make_card(named, WILD_VAL)};
        end else if (!ch.valid && model_cnt[0][WILD4_VAL] > 0) begin
            ch = {1'b1, make_card(named, WILD4_VAL)};
        end
        return ch;
    endfunction

    task automatic check_card(input string name, input card_t got, input card_t want);
        if (got !== want) begin
            $display("ERR %0t %s got %0d/%0d expected %0d/%0d", $time, name,
                     got.color, got.value, want.color, want.value);
            err_count++;
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                               input logic [COUNT_W-1:0] want);
        if (got !== want) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, want);
            err_count++;
        end
    endtask

    task automatic check_score(input string name, input logic [SCORE_W-1:0] got,
                               input logic [SCORE_W-1:0] want);
        if (got !== want) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, want);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, want);
            err_count++;
        end
    endtask

    task automatic apply_reset();
        if ($time > 0) @(posedge i_clk);
        i_rst_n       <= 1'b0;
        i_init        <= 1'b0;
        i_start       <= 1'b0;
        i_draw_two    <= 1'b0;
        i_draw_four   <= 1'b0;
        i_drawn       <= 1'b0;
        i_check       <= 1'b0;
        i_prev_card   <= '0;
        i_drawed_card <= '0;
        for (int c = 0; c < NUM_COLORS; c++) begin
            for (int v = 0; v < 15; v++) model_cnt[c][v] = 0;
        end
        model_num   = 0;
        model_score = 0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
    endtask

    // sends one i_drawn pulse and returns on the edge that takes the card
    task automatic send_card(input card_t k);
        @(posedge i_clk);
        i_drawn       <= 1'b1;
        i_drawed_card <= k;
        @(posedge i_clk);
        i_drawn <= 1'b0;
        model_apply(k, 1);
    endtask

    task automatic random_card(output card_t k);
        logic [5:0] bits;
        logic       found;
        bits  = '0;
        found = 1'b0;
        while (!found) begin
            for (int i = 0; i < 6; i++) begin
                lfsr = lfsr_next(lfsr);
                bits = {bits[4:0], lfsr[0]};
            end
            k     = make_card(color_e'(bits[5:4]), bits[3:0]);
            found = (bits[3:0] != 4'hf) && (model_cnt[cell_color(k)][k.value] < 3);
        end
    endtask

    task automatic deal_hand(input logic use_lfsr, input card_t [DEAL-1:0] cards);
        card_t k;
        @(posedge i_clk);
        i_init <= 1'b1;
        @(posedge i_clk);
        i_init <= 1'b0;
        for (int i = 0; i < DEAL; i++) begin
            if (use_lfsr) random_card(k);
            else k = cards[i];
            send_card(k);
        end
    endtask

    // supply holds the penalty cards, or in slot 0 the card given when nothing plays
    task automatic do_turn(input card_t prev, input int n_pen, input card_t [1:0] supply);
        play_choice_t want;
        @(posedge i_clk);
        i_prev_card <= prev;
        i_start     <= 1'b1;
        i_draw_two  <= (n_pen == 2);
        i_draw_four <= (n_pen == 4);
        @(posedge i_clk);
        i_start     <= 1'b0;
        i_draw_two  <= 1'b0;
        i_draw_four <= 1'b0;
        for (int i = 0; i < n_pen; i++) send_card(supply[i]);
        want = expected_choice(prev);
        @(posedge i_clk); // selection registered
        @(negedge i_clk);
        check_bit("o_out", o_out, 1'b0);
        check_bit("o_draw_card", o_draw_card, 1'b0);
        @(posedge i_clk);
        @(negedge i_clk);
        if (want.valid) begin
            if (o_out !== 1'b1) begin
                $display("%0t: o_out did not rise 2 cycles after the turn began", $time);
                err_count++;
            end
            check_bit("o_draw_card", o_draw_card, 1'b0);
            check_card("o_out_card", o_out_card, want.card);
            model_apply(want.card, -1);
            @(posedge i_clk);
            i_check <= 1'b1;
            @(posedge i_clk);
            i_check <= 1'b0;
            @(negedge i_clk);
            check_bit("o_out", o_out, 1'b0);
        end else begin
            if (o_draw_card !== 1'b1) begin
                $display("%0t: o_draw_card did not rise 2 cycles after the turn began", $time);
                err_count++;
            end
            check_bit("o_out", o_out, 1'b0);
            send_card(supply[0]);
            @(posedge i_clk); // i_check low lets it go idle
            @(negedge i_clk);
            check_bit("o_draw_card", o_draw_card, 1'b0);
            check_bit("o_out", o_out, 1'b0);
        end
        check_count("o_hand_num", o_hand_num, COUNT_W'(model_num));
        check_score("o_score", o_score, SCORE_W'(model_score));
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic reset_values();
        int e0;
        e0 = err_count;
        @(negedge i_clk);
        check_bit("o_out", o_out, 1'b0);
        check_bit("o_draw_card", o_draw_card, 1'b0);
        check_card("o_out_card", o_out_card, '0);
        check_count("o_hand_num", o_hand_num, '0);
        check_score("o_score", o_score, '0);
        report_test("reset values", e0);
    endtask

    task automatic random_deal();
        int e0;
        e0 = err_count;
        deal_hand(1'b1, '0);
        @(negedge i_clk);
        check_count("o_hand_num", o_hand_num, COUNT_W'(DEAL));
        check_score("o_score", o_score, SCORE_W'(model_score));
        report_test("random deal", e0);
    endtask

    task automatic colour_match();
        int     e0;
        color_e col;
        e0  = err_count;
        col = RED;
        for (int c = 0; c < NUM_COLORS; c++) begin // highest colour with a face card
            for (int v = 0; v < NUM_FACES; v++) begin
                if (model_cnt[c][v] > 0) col = color_e'(c);
            end
        end
        do_turn(make_card(col, 11), 0, '0);
        report_test("colour match", e0);
    endtask

    task automatic value_match();
        int e0;
        e0 = err_count;
        apply_reset();
        deal_hand(1'b0, {make_card(RED, 2), make_card(GREEN, 5), make_card(YELLOW, 5),
                         make_card(GREEN, 9), make_card(RED, 11), make_card(GREEN, WILD_VAL),
                         make_card(YELLOW, 0)});
        do_turn(make_card(BLUE, 5), 0, '0); // yellow 5 beats green 5 and the wild
        report_test("value match", e0);
    endtask

    task automatic wild_play();
        int e0;
        e0 = err_count;
        apply_reset();
        deal_hand(1'b0, {make_card(RED, 8), make_card(GREEN, 1), make_card(YELLOW, 12),
                         make_card(BLUE, WILD4_VAL), make_card(BLUE, WILD_VAL),
                         make_card(GREEN, 10), make_card(RED, 0)});
        do_turn(make_card(BLUE, 3), 0, '0);
        do_turn(make_card(BLUE, 3), 0, '0); // only the draw four is left
        apply_reset();
        deal_hand(1'b0, {make_card(RED, WILD_VAL), make_card(RED, WILD_VAL),
                         make_card(RED, WILD_VAL), make_card(RED, WILD4_VAL),
                         make_card(RED, WILD4_VAL), make_card(RED, WILD4_VAL),
                         make_card(YELLOW, 5)});
        do_turn(make_card(YELLOW, 7), 0, '0);
        do_turn(make_card(BLUE, 3), 0, '0); // only wilds left so blue wraps to red
        report_test("wild play", e0);
    endtask

    task automatic penalty_and_no_card();
        int e0;
        e0 = err_count;
        apply_reset();
        deal_hand(1'b0, {make_card(RED, 4), make_card(RED, 6), make_card(YELLOW, 2),
                         make_card(GREEN, 7), make_card(BLUE, 9), make_card(GREEN, 3),
                         make_card(YELLOW, 11)});
        do_turn(make_card(RED, 10), 2, {make_card(BLUE, 0), make_card(RED, 1)});
        apply_reset();
        deal_hand(1'b0, {make_card(RED, 1), make_card(RED, 2), make_card(YELLOW, 3),
                         make_card(GREEN, 4), make_card(YELLOW, 5), make_card(GREEN, 6),
                         make_card(RED, 7)});
        do_turn(make_card(BLUE, 8), 0, {make_card(RED, 0), make_card(BLUE, 8)});
        report_test("penalty and no card", e0);
    endtask

    initial begin
        apply_reset();
        reset_values();
        random_deal();
        colour_match();
        value_match();
        wild_play();
        penalty_and_no_card();
        $display("tests passed %0d failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/card_player_top.sv */
`default_nettype none
`timescale 1ns/100ps

module card_player_top import uno_pkg::*; #(
    parameter int INIT_HAND = 7
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_init,
    input  logic               i_start,
    input  logic               i_draw_two,
    input  logic               i_draw_four,
    input  logic               i_drawn,
    input  logic               i_check,
    input  card_t              i_prev_card,
    input  card_t              i_drawed_card,
    output card_t              o_out_card,
    output logic               o_out,
    output logic               o_draw_card,
    output logic [COUNT_W-1:0] o_hand_num,
    output logic [SCORE_W-1:0] o_score
);

    hand_op_t     hand_op;
    hand_view_t   hand_view;
    play_choice_t choice;

    turn_controller #(
        .INIT_HAND (INIT_HAND)
    ) u_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init        (i_init),
        .i_start       (i_start),
        .i_draw_two    (i_draw_two),
        .i_draw_four   (i_draw_four),
        .i_drawn       (i_drawn),
        .i_check       (i_check),
        .i_drawed_card (i_drawed_card),
        .i_choice      (choice),
        .o_hand_op     (hand_op),
        .o_out_card    (o_out_card),
        .o_out         (o_out),
        .o_draw_card   (o_draw_card)
    );

    hand_store u_hand (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op       (hand_op),
        .o_view     (hand_view),
        .o_hand_num (o_hand_num),
        .o_score    (o_score)
    );

    play_selector u_sel (
        .i_view      (hand_view),
        .i_prev_card (i_prev_card),
        .o_choice    (choice)
    );

endmodule

`default_nettype wire

/* source/turn_controller.sv */
`default_nettype none
`timescale 1ns/100ps

module turn_controller import uno_pkg::*; #(
    parameter int INIT_HAND = 7
) (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_init,
    input  logic         i_start,
    input  logic         i_draw_two,
    input  logic         i_draw_four,
    input  logic         i_drawn,
    input  logic         i_check,
    input  card_t        i_drawed_card,
    input  play_choice_t i_choice,
    output hand_op_t     o_hand_op,
    output card_t        o_out_card,
    output logic         o_out,
    output logic         o_draw_card
);

    // wide enough for the deal and for a draw four
    localparam int REM_W = $clog2(((INIT_HAND > 4) ? INIT_HAND : 4) + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_DRAW,
        S_SELECT,
        S_OUT,
        S_NO_CARD,
        S_WAIT_CHECK
    } state_e;

    state_e           state;
    logic [REM_W-1:0] remain;       // cards still to take in S_DRAW
    logic             turn_pending; // penalty draws lead into a select
    logic             take_card;

    assign take_card = i_drawn &&
                       (state == S_DRAW || (state == S_NO_CARD && o_draw_card));

    // table strobes land on the same edge the FSM moves, so the view is
    // already current when S_SELECT samples the choice
    always_comb begin
        o_hand_op = '0;
        if (take_card) begin
            o_hand_op.insert = 1'b1;
            o_hand_op.card   = i_drawed_card;
        end else if (state == S_SELECT && i_choice.valid) begin
            o_hand_op.remove = 1'b1;
            o_hand_op.card   = i_choice.card;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= S_IDLE;
            remain       <= '0;
            turn_pending <= 1'b0;
            o_out        <= 1'b0;
            o_draw_card  <= 1'b0;
            o_out_card   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        turn_pending <= 1'b1;
                        if (i_draw_two) begin
                            state  <= S_DRAW;
                            remain <= REM_W'(2);
                        end else if (i_draw_four) begin
                            state  <= S_DRAW;
                            remain <= REM_W'(4);
                        end else begin
                            state <= S_SELECT;
                        end
                    end else if (i_init) begin
                        state        <= S_DRAW;
                        remain       <= REM_W'(INIT_HAND);
                        turn_pending <= 1'b0; // deal ends in idle
                    end
                end
                S_DRAW: begin
                    if (i_drawn) begin
                        remain <= remain - 1'b1;
                        if (remain == REM_W'(1)) begin
                            state <= turn_pending ? S_SELECT : S_IDLE;
                        end
                    end
                end
                S_SELECT: begin
                    o_out_card <= i_choice.card;
                    state      <= i_choice.valid ? S_OUT : S_NO_CARD;
                end
                S_OUT: begin
                    if (o_out && i_check) begin
                        o_out      <= 1'b0;
                        o_out_card <= '0;
                        state      <= S_IDLE;
                    end else begin
                        o_out <= 1'b1;
                    end
                end
                S_NO_CARD: begin
                    if (o_draw_card && i_drawn) begin
                        o_draw_card <= 1'b0;
                        state       <= S_WAIT_CHECK;
                    end else begin
                        o_draw_card <= 1'b1;
                    end
                end
                S_WAIT_CHECK: begin
                    if (!i_check) state <= S_IDLE; // drawn card is kept, not played
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_out_or_draw: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_out && o_draw_card));

    // the played card must not move until the host has taken it
    a_out_card_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_out && !i_check) |=> $stable(o_out_card));

endmodule

`default_nettype wire

/* source/play_selector.sv */
`default_nettype none
`timescale 1ns/100ps

module play_selector import uno_pkg::*; (
    input  hand_view_t   i_view,
    input  card_t        i_prev_card,
    output play_choice_t o_choice
);

    logic                  prev_is_face;
    logic [3:0]            face_idx;
    logic [NUM_COLORS-1:0] value_held; // colours holding the previous value
    color_e                wild_color;

    function automatic logic [3:0] lowest_face(input logic [NUM_FACES-1:0] mask);
        logic [3:0] idx;
        idx = '0;
        for (int v = NUM_FACES - 1; v >= 0; v--) begin
            if (mask[v]) begin
                idx = 4'(v);
            end
        end
        return idx;
    endfunction

    function automatic color_e lowest_color(input logic [NUM_COLORS-1:0] mask);
        color_e col;
        col = RED;
        for (int c = NUM_COLORS - 1; c >= 0; c--) begin
            if (mask[c]) begin
                col = color_e'(c);
            end
        end
        return col;
    endfunction

    assign prev_is_face = (i_prev_card.value < NUM_FACES);
    assign face_idx     = prev_is_face ? i_prev_card.value : 4'd0;

    always_comb begin
        for (int c = 0; c < NUM_COLORS; c++) begin
            value_held[c] = i_view.present[c][face_idx];
        end
    end

    // with no colour card left, step one colour past the previous one
    assign wild_color = (|i_view.color_held) ? lowest_color(i_view.color_held) :
                                               color_e'(i_prev_card.color + 2'd1);

    always_comb begin
        o_choice = '0;
        if (prev_is_face && i_view.color_held[i_prev_card.color]) begin
            o_choice.valid      = 1'b1;
            o_choice.card.color = i_prev_card.color;
            o_choice.card.value = lowest_face(i_view.present[i_prev_card.color]);
        end else if (prev_is_face && |value_held) begin
            o_choice.valid      = 1'b1;
            o_choice.card.color = lowest_color(value_held);
            o_choice.card.value = i_prev_card.value;
        end else if (i_view.wild_held) begin
            o_choice.valid      = 1'b1;
            o_choice.card.color = wild_color;
            o_choice.card.value = WILD_VAL;
        end else if (i_view.wild4_held) begin
            o_choice.valid      = 1'b1;
            o_choice.card.color = wild_color;
            o_choice.card.value = WILD4_VAL;
        end
    end

endmodule

`default_nettype wire

/* source/hand_store.sv */
`default_nettype none
`timescale 1ns/100ps

module hand_store import uno_pkg::*; (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  hand_op_t           i_op,
    output hand_view_t         o_view,
    output logic [COUNT_W-1:0] o_hand_num,
    output logic [SCORE_W-1:0] o_score
);

    logic [1:0]         face_cnt [NUM_COLORS][NUM_FACES]; // up to 3 copies per cell
    logic [1:0]         wild_cnt;
    logic [1:0]         wild4_cnt;
    logic [1:0]         target_cnt;
    logic [1:0]         next_cnt;
    logic               is_wild;
    logic               is_wild4;
    logic               is_face;
    logic [SCORE_W-1:0] op_points;

    assign is_wild  = (i_op.card.value == WILD_VAL);
    assign is_wild4 = (i_op.card.value == WILD4_VAL);
    assign is_face  = (i_op.card.value < NUM_FACES);

    // wilds ignore the colour field
    always_comb begin
        if (is_wild) begin
            target_cnt = wild_cnt;
        end else if (is_wild4) begin
            target_cnt = wild4_cnt;
        end else if (is_face) begin
            target_cnt = face_cnt[i_op.card.color][i_op.card.value];
        end else begin
            target_cnt = '0;
        end
    end

    assign next_cnt  = i_op.insert ? target_cnt + 2'd1 : target_cnt - 2'd1;
    assign op_points = card_points(i_op.card);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int c = 0; c < NUM_COLORS; c++) begin
                for (int v = 0; v < NUM_FACES; v++) begin
                    face_cnt[c][v] <= '0;
                end
            end
            wild_cnt  <= '0;
            wild4_cnt <= '0;
        end else if (i_op.insert || i_op.remove) begin
            if (is_wild) begin
                wild_cnt <= next_cnt;
            end else if (is_wild4) begin
                wild4_cnt <= next_cnt;
            end else if (is_face) begin
                face_cnt[i_op.card.color][i_op.card.value] <= next_cnt;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hand_num <= '0;
            o_score    <= '0;
        end else if (i_op.insert) begin
            o_hand_num <= o_hand_num + COUNT_W'(1);
            o_score    <= o_score + op_points;
        end else if (i_op.remove) begin
            o_hand_num <= o_hand_num - COUNT_W'(1);
            o_score    <= o_score - op_points;
        end
    end

    always_comb begin
        for (int c = 0; c < NUM_COLORS; c++) begin
            for (int v = 0; v < NUM_FACES; v++) begin
                o_view.present[c][v] = |face_cnt[c][v];
            end
            o_view.color_held[c] = |o_view.present[c];
        end
        o_view.wild_held  = |wild_cnt;
        o_view.wild4_held = |wild4_cnt;
    end

    // controller sequences draws and plays, so strobes never overlap
    a_op_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_op.insert && i_op.remove));

    // selector may only pick a card that the table says is held
    a_remove_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_op.remove |-> (target_cnt != 2'd0));

endmodule

`default_nettype wire

/* source/uno_pkg.sv */
`default_nettype none

package uno_pkg;

    localparam int NUM_COLORS = 4;
    localparam int NUM_FACES  = 13; // colour faces 0..12

    localparam logic [3:0] WILD_VAL  = 4'd13;
    localparam logic [3:0] WILD4_VAL = 4'd14;

    localparam int COUNT_W = 7;
    localparam int SCORE_W = 11;

    typedef enum logic [1:0] {
        RED    = 2'd0,
        YELLOW = 2'd1,
        GREEN  = 2'd2,
        BLUE   = 2'd3
    } color_e;

    typedef struct packed {
        color_e     color;
        logic [3:0] value;
    } card_t;

    // what the selector needs to know about the hand
    typedef struct packed {
        logic [NUM_COLORS-1:0][NUM_FACES-1:0] present;
        logic [NUM_COLORS-1:0]                color_held;
        logic                                 wild_held;
        logic                                 wild4_held;
    } hand_view_t;

    typedef struct packed {
        logic  valid;
        card_t card;  // wilds carry the named colour
    } play_choice_t;

    typedef struct packed {
        logic  insert;
        logic  remove;
        card_t card;
    } hand_op_t;

    function automatic logic [SCORE_W-1:0] card_points(input card_t card);
        logic [SCORE_W-1:0] pts;
        if (card.value == WILD_VAL || card.value == WILD4_VAL) begin
            pts = SCORE_W'(50);
        end else if (card.value >= 4'd10) begin
            pts = SCORE_W'(20); // action faces
        end else begin
            pts = SCORE_W'(card.value);
        end
        return pts;
    endfunction

endpackage

`default_nettype wire
